// ==== logic/mcu_reg_pkg.sv ====
package mcu_reg_pkg;

    ////////////////////////////////////////
    // mcu register file geometry
    ////////////////////////////////////////

    // one mcu register word
    localparam int reg_word_w = 16;
    // register index width, four registers
    localparam int reg_idx_w = 2;

    // register indices
    // address high word
    localparam logic [reg_idx_w-1:0] reg_ad_hi = 2'd0;
    // address low word, also the trigger
    localparam logic [reg_idx_w-1:0] reg_ad_lo = 2'd1;
    // data word, holds write data or read result
    localparam logic [reg_idx_w-1:0] reg_data = 2'd2;
    // status word, read only
    localparam logic [reg_idx_w-1:0] reg_status = 2'd3;

    ////////////////////////////////////////
    // mcu access and status layout
    ////////////////////////////////////////

    // one register access per cycle
    typedef struct packed {
        logic                  load;
        logic                  read;
        logic [reg_idx_w-1:0]  idx;
        logic [reg_word_w-1:0] load_data;
    } mcu_req_t;

    // status word, flags in the low bits
    typedef struct packed {
        logic [reg_word_w-6:0] pad;
        logic [2:0]            cmd_count;
        logic                  fifo_full;
        logic                  read_pending;
    } status_t;

endpackage

// ==== logic/avalon_pkg.sv ====
package avalon_pkg;

    ////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////

    // full byte address, high and low words together
    localparam int av_addr_w = 32;
    // bus data word
    localparam int av_data_w = 16;

    // posted command queue
    localparam int cmd_depth = 4;
    // count must reach cmd_depth itself
    localparam int cmd_cnt_w = 3;

    ////////////////////////////////////////
    // command and response
    ////////////////////////////////////////

    // one queued bus transaction
    typedef struct packed {
        logic                 is_write;
        logic [av_addr_w-1:0] address;
        logic [av_data_w-1:0] writedata;
    } av_cmd_t;

    // read result back to the front end
    typedef struct packed {
        logic [av_data_w-1:0] readdata;
    } av_rsp_t;

    // master side of the avalon-mm port
    typedef struct packed {
        logic [av_addr_w-1:0] address;
        logic                 read;
        logic                 write;
        logic [av_data_w-1:0] writedata;
    } av_m_t;

endpackage

// ==== logic/av_reg_front.sv ====
`timescale 1ns/1ps

module av_reg_front
    import mcu_reg_pkg::*, avalon_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  arst_n,
    // mcu register strobes
    input  mcu_req_t              mcu_req,
    output logic [reg_word_w-1:0] reg_rdata,
    output logic                  mcu_wait,
    // command toward the fifo
    output av_cmd_t               cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    input  logic [cmd_cnt_w-1:0]  fifo_count,
    // read result from the master
    input  av_rsp_t               rsp,
    input  logic                  rsp_valid
);

    ////////////////////////////////////////
    // register file state
    ////////////////////////////////////////

    logic [reg_word_w-1:0] ad_hi;
    logic [reg_word_w-1:0] ad_lo;
    logic [reg_word_w-1:0] data_reg;
    logic                  read_pending;

    logic    hit_ad_lo;
    logic    trig_write;
    logic    trig_read;
    logic    fifo_full;
    status_t status;

    // address low is the trigger register
    assign hit_ad_lo  = (mcu_req.idx == reg_ad_lo);
    assign trig_write = mcu_req.load && hit_ad_lo;
    assign trig_read  = mcu_req.read && hit_ad_lo;

    // fifo full when every entry is occupied
    assign fifo_full = (fifo_count == cmd_cnt_w'(cmd_depth));

    ////////////////////////////////////////
    // command build
    ////////////////////////////////////////

    // valid in the strobe cycle itself
    assign cmd_valid = trig_write || trig_read;

    always_comb begin
        cmd.is_write  = trig_write;
        cmd.writedata = data_reg;
        // write takes the low word being loaded right now
        if (trig_write) begin
            cmd.address = {ad_hi, mcu_req.load_data};
        end else begin
            cmd.address = {ad_hi, ad_lo};
        end
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            ad_hi        <= '0;
            ad_lo        <= '0;
            data_reg     <= '0;
            read_pending <= 1'b0;
        end else begin
            if (mcu_req.load && mcu_req.idx == reg_ad_hi) begin
                ad_hi <= mcu_req.load_data;
            end
            if (trig_write) begin
                ad_lo <= mcu_req.load_data;
            end
            // response wins over the mcu
            if (rsp_valid) begin
                data_reg <= rsp.readdata;
            end else if (mcu_req.load && mcu_req.idx == reg_data && !read_pending) begin
                // mcu load dropped while a read is outstanding
                data_reg <= mcu_req.load_data;
            end
            // pending from accepted read until its response
            if (rsp_valid) begin
                read_pending <= 1'b0;
            end else if (trig_read && cmd_ready) begin
                read_pending <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // mcu side outputs
    ////////////////////////////////////////

    // stall on outstanding read or full queue
    // a queued write alone never stalls
    assign mcu_wait = read_pending || fifo_full;

    always_comb begin
        status              = '0;
        status.read_pending = read_pending;
        status.fifo_full    = fifo_full;
        status.cmd_count    = fifo_count;
    end

    // readback for the index of this cycle
    always_comb begin
        case (mcu_req.idx)
            reg_ad_hi: reg_rdata = ad_hi;
            reg_ad_lo: reg_rdata = ad_lo;
            reg_data:  reg_rdata = data_reg;
            default:   reg_rdata = status;
        endcase
    end

endmodule

// ==== logic/av_cmd_fifo.sv ====
`timescale 1ns/1ps

module av_cmd_fifo
    import avalon_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 arst_n,
    // producer side
    input  av_cmd_t              in_cmd,
    input  logic                 in_valid,
    output logic                 in_ready,
    // consumer side at the head of queue
    output av_cmd_t              out_cmd,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [cmd_cnt_w-1:0] count
);

    typedef logic [$clog2(cmd_depth)-1:0] ptr_t;

    ////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////

    av_cmd_t mem [cmd_depth];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;

    logic push;
    logic pop;

    assign in_ready  = (count != cmd_cnt_w'(cmd_depth));
    assign out_valid = (count != '0);

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // first word fall through with the head read straight from memory
    // new entry shows one cycle after its push
    assign out_cmd = mem[rd_ptr];

    // entry storage written on push
    always_ff @(posedge sysclk) begin
        if (push) begin
            mem[wr_ptr] <= in_cmd;
        end
    end

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(cmd_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(cmd_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push with pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/av_master.sv ====
`timescale 1ns/1ps

module av_master
    import avalon_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 arst_n,
    // head of the command fifo
    input  av_cmd_t              head,
    input  logic                 head_valid,
    output logic                 head_ready,
    // avalon-mm master port
    output av_m_t                av_m,
    input  logic                 av_waitrequest,
    input  logic [av_data_w-1:0] av_readdata,
    // read result, one cycle pulse
    output av_rsp_t              rsp,
    output logic                 rsp_valid
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t state;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    // head taken only when no transaction is on the bus
    assign head_ready = (state == st_idle);

    ////////////////////////////////////////
    // fsm and bus registers
    ////////////////////////////////////////

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            av_m      <= '0;
            rsp_valid <= 1'b0;
        end else begin
            // pulse by default
            rsp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (head_valid) begin
                        // strobe goes out the cycle after the take
                        av_m.address   <= head.address;
                        av_m.writedata <= head.writedata;
                        av_m.write     <= head.is_write;
                        av_m.read      <= !head.is_write;
                        state          <= st_busy;
                    end
                end
                st_busy: begin
                    // bus held stable until waitrequest drops
                    if (!av_waitrequest) begin
                        av_m.read  <= 1'b0;
                        av_m.write <= 1'b0;
                        rsp_valid  <= av_m.read;
                        state      <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // read data capture
    ////////////////////////////////////////

    // sampled in the closing cycle of a read
    always_ff @(posedge sysclk) begin
        if (state == st_busy && av_m.read && !av_waitrequest) begin
            rsp.readdata <= av_readdata;
        end
    end

endmodule

// ==== logic/av_bridge_top.sv ====
`timescale 1ns/1ps

module av_bridge_top
    import mcu_reg_pkg::*, avalon_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  arst_n,
    // mcu register port
    input  mcu_req_t              mcu_req,
    output logic [reg_word_w-1:0] reg_rdata,
    output logic                  mcu_wait,
    // avalon-mm master port
    output av_m_t                 av_m,
    input  logic                  av_waitrequest,
    input  logic [av_data_w-1:0]  av_readdata
);

    ////////////////////////////////////////
    // internal links
    ////////////////////////////////////////

    // front end to fifo
    av_cmd_t              cmd;
    logic                 cmd_valid;
    logic                 cmd_ready;
    logic [cmd_cnt_w-1:0] fifo_count;

    // fifo to master
    av_cmd_t head;
    logic    head_valid;
    logic    head_ready;

    // master back to front end
    av_rsp_t rsp;
    logic    rsp_valid;

    ////////////////////////////////////////
    // producer, buffer, consumer
    ////////////////////////////////////////

    av_reg_front u_front (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .mcu_req    (mcu_req),
        .reg_rdata  (reg_rdata),
        .mcu_wait   (mcu_wait),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .fifo_count (fifo_count),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid)
    );

    // posted writes queue here
    av_cmd_fifo u_fifo (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .in_cmd    (cmd),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .out_cmd   (head),
        .out_valid (head_valid),
        .out_ready (head_ready),
        .count     (fifo_count)
    );

    av_master u_master (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .head           (head),
        .head_valid     (head_valid),
        .head_ready     (head_ready),
        .av_m           (av_m),
        .av_waitrequest (av_waitrequest),
        .av_readdata    (av_readdata),
        .rsp            (rsp),
        .rsp_valid      (rsp_valid)
    );

endmodule

// ==== dv/av_bridge_assertions.sv ====
`timescale 1ns/1ps

module av_bridge_assertions
    import avalon_pkg::*;
(
    input logic  sysclk,
    input logic  arst_n,
    input av_m_t av_m,
    input logic  av_waitrequest,
    input logic  mcu_wait,
    input logic  rsp_valid
);

    ////////////////////////////////////////
    // avalon master port rules
    ////////////////////////////////////////

    // one transaction kind at a time
    read_write_excl: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(av_m.read && av_m.write))
        else $error("read and write high together");

    // bus frozen while the slave stalls
    hold_on_wait: assert property (@(posedge sysclk) disable iff (!arst_n)
        (av_m.read || av_m.write) && av_waitrequest |=> $stable(av_m))
        else $error("bus changed under waitrequest");

    ////////////////////////////////////////
    // mcu and response side
    ////////////////////////////////////////

    // nothing pending right out of reset
    wait_low_after_reset: assert property (@(posedge sysclk)
        $rose(arst_n) |-> !mcu_wait)
        else $error("mcu_wait high after reset release");

    // single cycle pulse per read
    rsp_pulse: assert property (@(posedge sysclk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held for two cycles");

endmodule

bind av_bridge_top av_bridge_assertions u_assertions (
    .sysclk         (sysclk),
    .arst_n         (arst_n),
    .av_m           (av_m),
    .av_waitrequest (av_waitrequest),
    .mcu_wait       (mcu_wait),
    .rsp_valid      (rsp_valid)
);

// ==== dv/tb_av_bridge.sv ====
`timescale 1ns/1ps

module tb_av_bridge
    import mcu_reg_pkg::*, avalon_pkg::*;
();

    localparam logic [31:0] seed = 32'h4173;
    localparam logic [31:0] taps = 32'h80200003;
    localparam int n_wr = 8;
    localparam int n_rd = 8;
    localparam int n_bp = 7;
    localparam int n_burst = 4;
    // mcu accesses over all tests including drains
    localparam int n_ops = 6 + n_wr * 3 + n_rd * 3 + n_bp * 3 + n_burst * 3 + 3 + 4 + 20;
    localparam int cycle_limit = n_ops * 8 + 200;

    typedef struct packed {
        logic [31:0] addr;
        logic [15:0] data;
    } xact_t;

    logic                 sysclk;
    logic                 arst_n;
    mcu_req_t             mcu_req;
    logic [15:0]          reg_rdata;
    logic                 mcu_wait;
    av_m_t                av_m;
    logic                 av_waitrequest;
    logic [av_data_w-1:0] av_readdata;

    // slave memory and bookkeeping
    logic [15:0] slave_mem [logic [31:0]];
    logic [15:0] ref_mem [logic [31:0]];
    int          mem_gen;
    logic [31:0] slave_lfsr;
    logic [31:0] stim_lfsr;
    logic [1:0]  wait_left;
    logic        hold_bus;
    logic        watch_wait;
    logic [15:0] lo_shadow;
    logic [15:0] last_rd;
    xact_t       exp_wr_q[$];
    xact_t       act_wr_q[$];
    xact_t       exp_rd_q[$];
    xact_t       act_rd_q[$];
    int          errors;
    int          checks;
    int          cycles;

    av_bridge_top i_av_bridge_top (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .mcu_req        (mcu_req),
        .reg_rdata      (reg_rdata),
        .mcu_wait       (mcu_wait),
        .av_m           (av_m),
        .av_waitrequest (av_waitrequest),
        .av_readdata    (av_readdata)
    );

    always #10 sysclk = ~sysclk;

    ////////////////////////////////////////
    // random source and reference
    ////////////////////////////////////////

    // right shifting galois lfsr step
    function automatic logic [31:0] lfsr_next(input logic [31:0] st);
        return st[0] ? ((st >> 1) ^ taps) : (st >> 1);
    endfunction

    // one galois lfsr step per bit taken
    task automatic take_bits(input int n, inout logic [31:0] st, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    // never written words read back as low xor high
    function automatic logic [15:0] expected_read(input logic [31:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr[15:0] ^ addr[31:16];
    endfunction

    function automatic logic [15:0] slave_peek(input logic [31:0] addr);
        if (slave_mem.exists(addr)) begin
            return slave_mem[addr];
        end
        return addr[15:0] ^ addr[31:16];
    endfunction

    ////////////////////////////////////////
    // avalon slave model
    ////////////////////////////////////////

    // readdata follows the address and every completed write
    always @(av_m.address or mem_gen) begin
        av_readdata = slave_peek(av_m.address);
    end

    always @(posedge sysclk) begin
        logic [31:0] r;
        if (arst_n) begin
            if (hold_bus) begin
                av_waitrequest <= 1'b1;
            end else if ((av_m.read || av_m.write) && !av_waitrequest) begin
                if (av_m.write) begin
                    slave_mem[av_m.address] = av_m.writedata;
                    mem_gen = mem_gen + 1;
                    act_wr_q.push_back('{addr: av_m.address, data: av_m.writedata});
                end
                // wait states for the next transaction
                take_bits(2, slave_lfsr, r);
                wait_left <= r[1:0];
                av_waitrequest <= (r[1:0] != 2'd0);
            end else if ((av_m.read || av_m.write) && wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
                av_waitrequest <= (wait_left > 2'd1);
            end else begin
                av_waitrequest <= (wait_left != 2'd0);
            end
        end
    end

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    endtask

    always @(negedge sysclk) begin
        xact_t e;
        xact_t a;
        if (act_wr_q.size() > 0) begin
            a = act_wr_q.pop_front();
            checks++;
            if (exp_wr_q.size() == 0) begin
                errors++;
                $display("Error at %0t: slave saw a write nobody issued", $time);
            end else begin
                e = exp_wr_q.pop_front();
                if (a.addr != e.addr) begin
                    mismatch("av_m.address", e.addr, a.addr);
                end
                if (a.data != e.data) begin
                    mismatch("av_m.writedata", {16'h0, e.data}, {16'h0, a.data});
                end
            end
        end
        if (act_rd_q.size() > 0 && exp_rd_q.size() > 0) begin
            a = act_rd_q.pop_front();
            e = exp_rd_q.pop_front();
            checks++;
            if (a.data != e.data) begin
                mismatch("reg_rdata", {16'h0, e.data}, {16'h0, a.data});
            end
        end
        if (watch_wait && mcu_wait) begin
            errors++;
            watch_wait = 1'b0;
            $display("Error at %0t: mcu_wait rose during posted writes", $time);
        end
    end

    // run limit
    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, DUT stopped responding", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // mcu access tasks
    ////////////////////////////////////////

    // one strobe cycle then one idle cycle
    task automatic mcu_access(input logic ld, input logic rd, input logic [1:0] idx,
                              input logic [15:0] d, input logic skip_wait,
                              output logic [15:0] q);
        @(negedge sysclk);
        if (!skip_wait) begin
            while (mcu_wait) begin
                @(negedge sysclk);
            end
        end
        @(posedge sysclk);
        mcu_req <= '{load: ld, read: rd, idx: idx, load_data: d};
        @(negedge sysclk);
        q = reg_rdata;
        @(posedge sysclk);
        mcu_req <= '0;
    endtask

    task automatic reg_load(input logic [1:0] idx, input logic [15:0] d);
        logic [15:0] q;
        mcu_access(1'b1, 1'b0, idx, d, 1'b0, q);
    endtask

    task automatic reg_read(input logic [1:0] idx, output logic [15:0] q);
        mcu_access(1'b0, 1'b1, idx, 16'h0, 1'b0, q);
    endtask

    task automatic wait_idle();
        @(negedge sysclk);
        while (mcu_wait) begin
            @(negedge sysclk);
        end
    endtask

    // queue empty and bus quiet
    task automatic wait_drained();
        logic [15:0] q;
        do begin
            reg_read(reg_status, q);
        end while (q[4:2] != 3'd0 || q[0]);
        @(negedge sysclk);
        while (av_m.read || av_m.write) begin
            @(negedge sysclk);
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [15:0] d);
        reg_load(reg_ad_hi, addr[31:16]);
        reg_load(reg_data, d);
        reg_load(reg_ad_lo, addr[15:0]);
        lo_shadow = addr[15:0];
        ref_mem[addr] = d;
        exp_wr_q.push_back('{addr: addr, data: d});
    endtask

    // read of hi and the current low word
    task automatic do_read(input logic [15:0] hi, input logic force_load,
                           input logic [15:0] junk);
        logic [15:0] q;
        logic [31:0] addr;
        addr = {hi, lo_shadow};
        reg_load(reg_ad_hi, hi);
        reg_read(reg_ad_lo, q);
        @(negedge sysclk);
        if (!mcu_wait) begin
            errors++;
            $display("Error at %0t: mcu_wait did not rise for a read", $time);
        end
        if (force_load) begin
            // bus held so the read stays outstanding
            hold_bus = 1'b1;
            // strobes during the stall on purpose
            mcu_access(1'b1, 1'b0, reg_data, junk, 1'b1, q);
            mcu_access(1'b0, 1'b1, reg_data, 16'h0, 1'b1, q);
            // data register still holds the previous read result
            checks++;
            if (q != last_rd) begin
                mismatch("reg_rdata", {16'h0, last_rd}, {16'h0, q});
            end
            @(negedge sysclk);
            hold_bus = 1'b0;
        end
        wait_idle();
        reg_read(reg_data, q);
        last_rd = expected_read(addr);
        exp_rd_q.push_back('{addr: addr, data: last_rd});
        act_rd_q.push_back('{addr: addr, data: q});
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [15:0] q;
        logic        saw_full;
        int          e0;
        sysclk = 1'b0;
        arst_n = 1'b0;
        mcu_req = '0;
        av_waitrequest = 1'b0;
        slave_lfsr = seed;
        stim_lfsr = seed;
        wait_left = 2'd0;
        hold_bus = 1'b0;
        watch_wait = 1'b0;
        lo_shadow = 16'h0;
        last_rd = 16'h0;
        mem_gen = 0;
        errors = 0;
        checks = 0;
        cycles = 0;
        repeat (3) @(posedge sysclk);
        arst_n <= 1'b1;

        // register access
        e0 = errors;
        reg_load(reg_ad_hi, 16'h1234);
        reg_read(reg_ad_hi, q);
        checks++;
        if (q != 16'h1234) mismatch("reg_rdata", 32'h1234, {16'h0, q});
        reg_load(reg_data, 16'hbeef);
        reg_read(reg_data, q);
        checks++;
        if (q != 16'hbeef) mismatch("reg_rdata", 32'hbeef, {16'h0, q});
        do_write(32'h1234_5678, 16'hbeef);
        reg_read(reg_ad_lo, q);
        checks++;
        if (q != 16'h5678) mismatch("reg_rdata", 32'h5678, {16'h0, q});
        wait_drained();
        reg_read(reg_status, q);
        checks++;
        if (q != 16'h0) mismatch("reg_rdata", 32'h0, {16'h0, q});
        end_test("register access", e0);

        // posted writes
        e0 = errors;
        watch_wait = 1'b1;
        for (int i = 0; i < n_wr; i++) begin
            take_bits(32, stim_lfsr, a);
            take_bits(16, stim_lfsr, r);
            do_write(a, r[15:0]);
        end
        wait_drained();
        watch_wait = 1'b0;
        end_test("posted write", e0);

        // read round trip where even reads hit the last write
        e0 = errors;
        for (int i = 0; i < n_rd; i++) begin
            take_bits(16, stim_lfsr, r);
            if (i % 2 == 0) begin
                do_read(a[31:16], 1'b0, 16'h0);
            end else begin
                do_read(r[15:0], 1'b0, 16'h0);
            end
        end
        end_test("read round trip", e0);

        // back-pressure
        e0 = errors;
        saw_full = 1'b0;
        @(negedge sysclk);
        hold_bus = 1'b1;
        for (int i = 0; i < n_bp; i++) begin
            if (hold_bus) begin
                @(negedge sysclk);
                if (mcu_wait) begin
                    saw_full = 1'b1;
                    hold_bus = 1'b0;
                end
            end
            take_bits(32, stim_lfsr, a);
            take_bits(16, stim_lfsr, r);
            do_write(a, r[15:0]);
        end
        @(negedge sysclk);
        hold_bus = 1'b0;
        wait_drained();
        checks++;
        if (!saw_full) begin
            errors++;
            $display("Error at %0t: mcu_wait never rose with the bus held", $time);
        end
        end_test("back-pressure", e0);

        // write burst then read of the last address
        e0 = errors;
        for (int i = 0; i < n_burst; i++) begin
            take_bits(32, stim_lfsr, a);
            take_bits(16, stim_lfsr, r);
            do_write(a, r[15:0]);
        end
        do_read(a[31:16], 1'b0, 16'h0);
        end_test("read after writes", e0);

        // data load lost while a read is pending
        e0 = errors;
        wait_drained();
        do_read(a[31:16], 1'b1, ~ref_mem[a]);
        end_test("ignored data load", e0);

        wait_drained();
        repeat (4) @(negedge sysclk);
        if (exp_wr_q.size() != 0 || exp_rd_q.size() != 0 || act_rd_q.size() != 0) begin
            errors++;
            $display("Error: %0d writes and %0d reads were left unmatched",
                     exp_wr_q.size(), exp_rd_q.size() + act_rd_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/mcu_reg_pkg.sv
logic/avalon_pkg.sv
logic/av_reg_front.sv
logic/av_cmd_fifo.sv
logic/av_master.sv
logic/av_bridge_top.sv
dv/av_bridge_assertions.sv
dv/tb_av_bridge.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_av_bridge -f tb.f -o vsim
	out=$$(./obj_dir/vsim); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
